//--- colmix_config.svh
// ~~~~~~~~~~~~~~~~~~~~
// color mixer build constants
// palette depth, video delay and bus width
// ~~~~~~~~~~~~~~~~~~~~

`ifndef COLMIX_CONFIG_SVH
`define COLMIX_CONFIG_SVH

// palette index width
// two priority bits over eight color bits
`define CM_PAL_AW 10

// pixel enables from layer inputs to rgb outputs
// prio stage + ram read + one rgb stage
`define CM_BLANK_DLY 3

// apb byte address width
// word index sits at paddr[CM_PAL_AW:1]
`define CM_APB_AW 12

// apb data width, fixed by the palette word layout
`define CM_APB_DW 16

`endif

//--- pixel_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// pixel path types
// layer codes, priority code, palette lane words, rgb
// ~~~~~~~~~~~~~~~~~~~~

package pixel_pkg;

    // color codes of all four layers for one pixel
    typedef struct packed {
        logic [5:0] char;   // character layer
        logic [8:0] scr1;   // scroll 1, bit 8 unused by the palette
        logic [7:0] scr2;   // scroll 2
        logic [7:0] obj;    // sprites
    } layer_pix_t;

    // priority code, goes on top of the palette index
    typedef enum logic [1:0] {
        SEL_SCR2 = 2'd0,
        SEL_SCR1 = 2'd1,
        SEL_OBJ  = 2'd2,
        SEL_CHR  = 2'd3
    } layer_sel_t;

    // red lane of the palette
    typedef logic [3:0] pal_red_t;

    // green/blue lane, green in the upper nibble
    typedef struct packed {
        logic [3:0] green;
        logic [3:0] blue;
    } pal_gb_t;

    // 12-bit color out of the mixer
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

//--- bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// apb bus types for the palette port
// ~~~~~~~~~~~~~~~~~~~~

`include "colmix_config.svh"

package bus_pkg;

    // master to slave
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [`CM_APB_AW-1:0] paddr;    // byte address
        logic [`CM_APB_DW-1:0] pwdata;
        logic [1:0]            pstrb;    // bit 1 red lane, bit 0 gb lane
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic                  pready;
        logic [`CM_APB_DW-1:0] prdata;
        logic                  pslverr;
    } apb_rsp_t;

endpackage

//--- layer_prio.sv
// ~~~~~~~~~~~~~~~~~~~~
// layer priority stage
// picks char, obj, scr1 or scr2 per pixel and
// registers the palette index
// ~~~~~~~~~~~~~~~~~~~~

`include "colmix_config.svh"

module layer_prio
    import pixel_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  logic [3:0]           layer_en,  // char, scr1, scr2, obj
    input  layer_pix_t           pix,
    output logic [`CM_PAL_AW-1:0] pal_idx
);

    // debug enables
    logic en_char;
    logic en_scr1;
    logic en_scr2;
    logic en_obj;

    // transparency, low bits all ones
    logic char_clr;
    logic obj_clr;
    logic scr1_clr;

    layer_sel_t sel;
    logic [7:0] color;  // selected color code, 8 bits

    assign en_char = layer_en[0];
    assign en_scr1 = layer_en[1];
    assign en_scr2 = layer_en[2];
    assign en_obj  = layer_en[3];

    assign char_clr = &pix.char[1:0];
    assign obj_clr  = &pix.obj[3:0];
    assign scr1_clr = &pix.scr1[3:0];

    // fixed order, first opaque enabled layer wins
    always_comb begin
        if (en_char && !char_clr)
            sel = SEL_CHR;
        else if (en_obj && !obj_clr)
            sel = SEL_OBJ;
        else if (en_scr1 && !scr1_clr)
            sel = SEL_SCR1;
        else
            sel = SEL_SCR2;     // background fallback
    end

    always_comb begin
        case (sel)
            SEL_CHR:  color = {2'b00, pix.char};
            SEL_OBJ:  color = pix.obj;
            SEL_SCR1: color = pix.scr1[7:0];   // bit 8 dropped
            default:  color = en_scr2 ? pix.scr2 : 8'h00;
        endcase
    end

    // index register, one pixel of latency
    always_ff @(posedge clk) begin
        if (rst)
            pal_idx <= '0;
        else if (pxl_cen)
            pal_idx <= {sel, color};
    end

endmodule

//--- palette_ram.sv
// ~~~~~~~~~~~~~~~~~~~~
// palette ram lane
// single port, registered read
// ~~~~~~~~~~~~~~~~~~~~

module palette_ram #(
    parameter type data_t = logic [7:0],
    parameter int  AW     = 10
) (
    input  logic          clk,
    input  logic [AW-1:0] addr,
    input  logic          we,
    input  data_t         din,
    output data_t         q
);

    data_t mem [0:(2**AW)-1];

    // palette comes up black
    initial begin
        for (int i = 0; i < 2**AW; i++)
            mem[i] = '0;
    end

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= din;
        q <= mem[addr];     // read before write
    end

endmodule

//--- apb_pal_port.sv
// ~~~~~~~~~~~~~~~~~~~~
// apb palette port
// owns the palette address during blanking and
// stalls the bus during active video
// ~~~~~~~~~~~~~~~~~~~~

`include "colmix_config.svh"

module apb_pal_port
    import pixel_pkg::*, bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  apb_req_t              apb,
    output apb_rsp_t              apb_rsp,
    input  logic [`CM_PAL_AW-1:0] pal_idx,
    input  logic                  pre_active,  // ram busy with pixels
    output logic [`CM_PAL_AW-1:0] ram_addr,
    output logic                  red_we,
    output logic                  gb_we,
    output pal_red_t              red_din,
    output pal_gb_t               gb_din,
    input  pal_red_t              red_q,
    input  pal_gb_t               gb_q
);

    typedef enum logic [1:0] {
        ST_WAIT  = 2'd0,    // idle or stalled access phase
        ST_RDATA = 2'd1,    // read data on the bus
        ST_DONE  = 2'd2     // write or error response
    } port_st_t;

    port_st_t              state;
    logic                  err_q;
    logic                  grant;
    logic                  bad_addr;
    logic [`CM_PAL_AW-1:0] bus_idx;

    assign bus_idx  = apb.paddr[`CM_PAL_AW:1];
    // odd byte address, or past the last palette word
    assign bad_addr = apb.paddr[0] | (|(apb.paddr >> (`CM_PAL_AW + 1)));

    // first access cycle that finds the ram free
    assign grant = (state == ST_WAIT) && apb.psel && apb.penable && !pre_active;

    assign ram_addr = pre_active ? pal_idx : bus_idx;
    assign red_we   = grant && apb.pwrite && apb.pstrb[1] && !bad_addr;
    assign gb_we    = grant && apb.pwrite && apb.pstrb[0] && !bad_addr;
    assign red_din  = apb.pwdata[11:8];
    assign gb_din   = pal_gb_t'(apb.pwdata[7:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_WAIT;
            err_q <= 1'b0;
        end else begin
            case (state)
                ST_WAIT: begin
                    if (grant) begin
                        err_q <= bad_addr;
                        state <= (apb.pwrite || bad_addr) ? ST_DONE : ST_RDATA;
                    end
                end
                default: state <= ST_WAIT;  // response lasts one cycle
            endcase
        end
    end

    // q already holds the bus word in ST_RDATA
    always_comb begin
        apb_rsp.pready  = (state != ST_WAIT);
        apb_rsp.prdata  = (state == ST_RDATA) ? {4'h0, red_q, gb_q} : '0;
        apb_rsp.pslverr = (state == ST_DONE) && err_q;
    end

endmodule

//--- blank_delay.sv
// ~~~~~~~~~~~~~~~~~~~~
// blanking delay line
// lines the flags up with palette output, blacks out rgb
// ~~~~~~~~~~~~~~~~~~~~

`include "colmix_config.svh"

module blank_delay
    import pixel_pkg::*;
#(
    parameter int DLY = `CM_BLANK_DLY
) (
    input  logic clk,
    input  logic rst,
    input  logic pxl_cen,
    input  logic hblank_n,
    input  logic vblank_n,
    input  rgb_t rgb_in,        // straight from the palette lanes
    output logic pre_active,    // aligned with pal_idx
    output logic hblank_n_dly,
    output logic vblank_n_dly,
    output rgb_t rgb
);

    logic [DLY-1:0] hb_sr;
    logic [DLY-1:0] vb_sr;
    rgb_t           rgb_sr [DLY-2];    // prio and ram take the other two

    always_ff @(posedge clk) begin
        if (rst) begin
            hb_sr <= '0;
            vb_sr <= '0;
            for (int i = 0; i < DLY-2; i++)
                rgb_sr[i] <= '0;
        end else if (pxl_cen) begin
            hb_sr     <= {hb_sr[DLY-2:0], hblank_n};
            vb_sr     <= {vb_sr[DLY-2:0], vblank_n};
            rgb_sr[0] <= rgb_in;
            for (int i = 1; i < DLY-2; i++)
                rgb_sr[i] <= rgb_sr[i-1];
        end
    end

    assign pre_active   = hb_sr[0] & vb_sr[0];  // first stage only
    assign hblank_n_dly = hb_sr[DLY-1];
    assign vblank_n_dly = vb_sr[DLY-1];
    // black outside the visible area
    assign rgb = (hblank_n_dly && vblank_n_dly) ? rgb_sr[DLY-3] : '0;

endmodule

//--- colmix_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// color mixer top
// layer priority, palette lanes, apb port, blanking delay
// ~~~~~~~~~~~~~~~~~~~~

`include "colmix_config.svh"

module colmix_top
    import pixel_pkg::*, bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  logic [3:0] layer_en,    // debug, char scr1 scr2 obj
    input  layer_pix_t pix,
    input  logic       hblank_n,
    input  logic       vblank_n,
    input  apb_req_t   apb,
    output apb_rsp_t   apb_rsp,
    output rgb_t       rgb,
    output logic       hblank_n_dly,
    output logic       vblank_n_dly
);

    logic [`CM_PAL_AW-1:0] pal_idx;
    logic [`CM_PAL_AW-1:0] ram_addr;
    logic                  pre_active;
    logic                  red_we;
    logic                  gb_we;
    pal_red_t              red_din;
    pal_red_t              red_q;
    pal_gb_t               gb_din;
    pal_gb_t               gb_q;
    rgb_t                  pal_rgb;

    assign pal_rgb = {red_q, gb_q};    // red over green over blue

    layer_prio u_prio (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .layer_en (layer_en),
        .pix      (pix),
        .pal_idx  (pal_idx)
    );

    // red lane, 4 bits
    palette_ram #(.data_t(pal_red_t), .AW(`CM_PAL_AW)) u_pal_red (
        .clk  (clk),
        .addr (ram_addr),
        .we   (red_we),
        .din  (red_din),
        .q    (red_q)
    );

    // green/blue lane, 8 bits
    palette_ram #(.data_t(pal_gb_t), .AW(`CM_PAL_AW)) u_pal_gb (
        .clk  (clk),
        .addr (ram_addr),
        .we   (gb_we),
        .din  (gb_din),
        .q    (gb_q)
    );

    apb_pal_port u_port (
        .clk        (clk),
        .rst        (rst),
        .apb        (apb),
        .apb_rsp    (apb_rsp),
        .pal_idx    (pal_idx),
        .pre_active (pre_active),
        .ram_addr   (ram_addr),
        .red_we     (red_we),
        .gb_we      (gb_we),
        .red_din    (red_din),
        .gb_din     (gb_din),
        .red_q      (red_q),
        .gb_q       (gb_q)
    );

    blank_delay #(.DLY(`CM_BLANK_DLY)) u_blank (
        .clk          (clk),
        .rst          (rst),
        .pxl_cen      (pxl_cen),
        .hblank_n     (hblank_n),
        .vblank_n     (vblank_n),
        .rgb_in       (pal_rgb),
        .pre_active   (pre_active),
        .hblank_n_dly (hblank_n_dly),
        .vblank_n_dly (vblank_n_dly),
        .rgb          (rgb)
    );

endmodule

//--- tb_clkgen.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench clock source
// free running, period of 4
// ~~~~~~~~~~~~~~~~~~~~

module tb_clkgen (
    output logic clk
);

    initial clk = 1'b0;
    always #2 clk = ~clk;   // half period 2

endmodule

//--- colmix_chk.sv
// ~~~~~~~~~~~~~~~~~~~~
// color mixer checker
// apb handshake and output blanking assertions
// ~~~~~~~~~~~~~~~~~~~~

module colmix_chk
    import pixel_pkg::*, bus_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input apb_req_t apb,
    input apb_rsp_t apb_rsp,
    input rgb_t     rgb,
    input logic     hblank_n_dly,
    input logic     vblank_n_dly
);

    // pready belongs to an access phase
    a_pready_acc: assert property (@(posedge clk) disable iff (rst)
        $rose(apb_rsp.pready) |-> (apb.psel && apb.penable))
        else $error("pready rose without an access phase");

    // stalled master holds the whole request
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (apb.psel && apb.penable && !apb_rsp.pready) |=> $stable(apb))
        else $error("apb request changed while stalled");

    // black outside the visible area
    a_rgb_black: assert property (@(posedge clk) disable iff (rst)
        !(hblank_n_dly && vblank_n_dly) |-> (rgb == '0))
        else $error("rgb not black during blanking");

endmodule

bind colmix_top colmix_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .apb          (apb),
    .apb_rsp      (apb_rsp),
    .rgb          (rgb),
    .hblank_n_dly (hblank_n_dly),
    .vblank_n_dly (vblank_n_dly)
);

//--- colmix_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// color mixer testbench
// runs bus and pixel vectors from the tests file
// ~~~~~~~~~~~~~~~~~~~~

`include "colmix_config.svh"

module colmix_tb
    import pixel_pkg::*, bus_pkg::*;
();

    // one line of the tests file
    typedef struct packed {
        logic [7:0]            kind;    // W, R or P
        logic [8*20-1:0]       name;
        logic [`CM_APB_AW-1:0] addr;
        logic [15:0]           data;    // write data or expected read data
        logic [1:0]            strb;
        logic                  err;     // expected pslverr
        logic [7:0]            stall;   // active cycles before blanking
        logic [3:0]            en;
        layer_pix_t            pix;
        logic                  hb;
        logic                  vb;
        rgb_t                  exp_rgb;
    } test_t;

    logic       clk;
    logic       rst;
    logic       pxl_cen;
    logic [3:0] layer_en;
    layer_pix_t pix;
    logic       hblank_n;
    logic       vblank_n;
    apb_req_t   apb;
    apb_rsp_t   apb_rsp;
    rgb_t       rgb;
    logic       hblank_n_dly;
    logic       vblank_n_dly;

    test_t tests[$];
    int    mismatches = 0;
    int    failures   = 0;
    int    cycles     = 0;
    int    limit      = 0;  // set once the tests are loaded
    int    seed       = 36754;

    tb_clkgen u_clk (.clk(clk));

    colmix_top dut (.*);

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_rgb(input logic [8*20-1:0] name, input rgb_t want, input rgb_t got);
        if (want !== got) begin
            $display("MISMATCH %0s: rgb expected %h actual %h", name, want, got);
            mismatches++;
        end
    endtask

    task automatic check_rsp(input logic [8*20-1:0] name, input apb_rsp_t want,
                             input apb_rsp_t got);
        if (want !== got) begin
            $display("MISMATCH %0s: rsp expected %h actual %h", name, want, got);
            mismatches++;
        end
    endtask

    task automatic check_blank(input logic [8*20-1:0] name, input logic want_h,
                               input logic want_v, input logic got_h, input logic got_v);
        if ({want_h, want_v} !== {got_h, got_v}) begin
            $display("MISMATCH %0s: hblank/vblank expected %b%b actual %b%b",
                     name, want_h, want_v, got_h, got_v);
            mismatches++;
        end
    endtask

    // random layer codes while the bus runs
    task automatic idle_pixel();
        logic [31:0] rnd;
        rnd = $random(seed);
        pix = rnd[30:0];
    endtask

    task automatic load_tests(input int fd);
        test_t           t;
        int              code;
        logic            ok;
        logic [7:0]      kind;
        logic [8*20-1:0] nm;
        logic [8*80-1:0] line;
        logic [31:0]     f [8];
        while ($fscanf(fd, " %s", kind) == 1) begin
            t      = '0;
            t.kind = kind;
            ok     = 1'b0;
            case (kind)
                "#": code = $fgets(line, fd);   // comment, skip the rest
                "W": begin
                    code = $fscanf(fd, " %s %h %h %h %h %h", nm, f[0], f[1], f[2], f[3], f[4]);
                    ok   = (code == 6);
                    t.strb  = f[2][1:0];
                    t.err   = f[3][0];
                    t.stall = f[4][7:0];
                end
                "R": begin
                    code = $fscanf(fd, " %s %h %h %h", nm, f[0], f[1], f[2]);
                    ok   = (code == 4);
                    t.err = f[2][0];
                end
                "P": begin
                    code = $fscanf(fd, " %s %h %h %h %h %h %h %h %h", nm, f[0], f[1], f[2],
                                   f[3], f[4], f[5], f[6], f[7]);
                    ok   = (code == 9);
                    t.en  = f[0][3:0];
                    t.pix = '{char: f[1][5:0], scr1: f[2][8:0], scr2: f[3][7:0],
                              obj: f[4][7:0]};
                    t.hb  = f[5][0];
                    t.vb  = f[6][0];
                    t.exp_rgb = f[7][11:0];
                end
                default: code = 0;
            endcase
            t.name = nm;
            t.addr = f[0][`CM_APB_AW-1:0];
            t.data = f[1][15:0];
            if (kind != "#") begin
                if (ok)
                    tests.push_back(t);
                else begin
                    $display("bad line in the tests file, kind %c", kind);
                    failures++;
                end
            end
        end
    endtask

    // one apb transfer, blanking comes after t.stall active cycles
    task automatic bus_xfer(input test_t t, input logic wr, output apb_rsp_t rsp);
        @(negedge clk);
        apb = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: t.addr,
                pwdata: wr ? t.data : 16'h0, pstrb: wr ? t.strb : 2'b00};
        hblank_n = (t.stall != 0);
        vblank_n = 1'b1;
        idle_pixel();
        @(negedge clk);
        apb.penable = 1'b1;
        idle_pixel();
        repeat (t.stall) begin
            @(negedge clk);
            idle_pixel();
            if (apb_rsp.pready) begin
                $display("%0s: pready went high during active video", t.name);
                failures++;
            end
        end
        hblank_n = 1'b0;    // ram goes to the bus
        do begin
            @(negedge clk);
            idle_pixel();
        end while (!apb_rsp.pready);
        rsp = apb_rsp;
        @(negedge clk);     // transfer ends on the edge before this
        apb = '0;
    endtask

    // hold one pixel until it reaches the outputs
    task automatic pixel_run(input test_t t);
        logic [1:0] prev;
        prev = {hblank_n, vblank_n};
        @(negedge clk);
        layer_en = t.en;
        pix      = t.pix;
        hblank_n = t.hb;
        vblank_n = t.vb;
        for (int i = 1; i < `CM_BLANK_DLY; i++) begin
            @(negedge clk);
            check_blank(t.name, prev[1], prev[0], hblank_n_dly, vblank_n_dly);  // old flags
        end
        @(negedge clk);
        check_blank(t.name, t.hb, t.vb, hblank_n_dly, vblank_n_dly);
        check_rgb(t.name, t.exp_rgb, rgb);
    endtask

    initial begin
        test_t    t;
        apb_rsp_t rsp;
        apb_rsp_t want;
        int       fd;
        rst      = 1'b1;
        pxl_cen  = 1'b1;
        layer_en = 4'hf;
        pix      = '0;
        hblank_n = 1'b0;
        vblank_n = 1'b0;
        apb      = '0;
        fd = $fopen("colmix_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open colmix_tests.txt");
            failures++;
        end else begin
            load_tests(fd);
            $fclose(fd);
        end
        limit = 64 * (tests.size() + 1) + 16;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (tests[i]) begin
            t = tests[i];
            case (t.kind)
                "W", "R": begin
                    bus_xfer(t, t.kind == "W", rsp);
                    want.pready  = 1'b1;
                    want.prdata  = (t.kind == "W") ? 16'h0 : t.data;
                    want.pslverr = t.err;
                    check_rsp(t.name, want, rsp);
                end
                default: pixel_run(t);
            endcase
        end
        repeat (4) @(negedge clk);
        $display("errors: %0d mismatches, %0d other", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- colmix_tests.txt
# W name addr data strb exp_err stall | R name addr exp_data exp_err
# P name layer_en char scr1 scr2 obj hblank_n vblank_n exp_rgb   (all hex)
W w_chr       60A FABC 3 0 0
W w_obj       424 0123 3 0 0
W w_scr1      268 0F0F 3 0 0
W w_scr2      0AC 0456 3 0 0
W w_idx0      000 0789 3 0 0
W w_red_only  60A 0DFF 2 0 0
W w_gb_only   424 0E45 1 0 0
R r_chr       60A 0DBC 0
R r_obj       424 0145 0
R r_scr1      268 0F0F 0
R r_scr2      0AC 0456 0
W w_stall     0AC 0321 3 0 6
R r_stall     0AC 0321 0
W w_odd       0AD 0FFF 3 1 0
R r_odd_chk   0AC 0321 0
W w_range     800 0FFF 3 1 0
R r_range_chk 000 0789 0
R r_odd       0AD 0000 1
R r_range     9FE 0000 1
P p_chr_obj      F 05 034 56 12 1 1 DBC
P p_obj_scr1     F 03 034 56 12 1 1 145
P p_fall_scr1    F 07 034 56 1F 1 1 F0F
P p_fall_scr2    F 3F 03F 56 FF 1 1 321
P p_scr1_bit8    F 03 134 56 0F 1 1 F0F
P p_en_nochr     E 05 034 56 12 1 1 145
P p_en_noobj     6 05 034 56 12 1 1 F0F
P p_en_scr2      4 05 034 56 12 1 1 321
P p_scr2_off     0 05 034 56 12 1 1 789
P p_scr2_off_fb  B 3F 03F 56 FF 1 1 789
P p_hblank       F 05 034 56 12 0 1 000
P p_vblank       F 05 034 56 12 1 0 000
P p_both_blank   F 05 034 56 12 0 0 000
P p_back_on      F 05 034 56 12 1 1 DBC

//--- tb.f
+incdir+.
pixel_pkg.sv
bus_pkg.sv
layer_prio.sv
palette_ram.sv
apb_pal_port.sv
blank_delay.sv
colmix_top.sv
tb_clkgen.sv
colmix_chk.sv
colmix_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the color mixer testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module colmix_tb -o colmix_sim
./obj_dir/colmix_sim 2>&1 | tee sim.log
if grep -qF "** FAIL **" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
